// ==== design/cc_pkg.sv ====
package cc_pkg;

  // Field widths of the offload channel
  localparam int unsigned WordWidth = 32;
  localparam int unsigned IdWidth   = 5;
  localparam int unsigned OpWidth   = 3;

  // Flat request: op_valid, opcode, id, operand a, operand b
  localparam int unsigned ReqWidth  = 1 + OpWidth + IdWidth + 2 * WordWidth;
  // Flat response: result, id, error
  localparam int unsigned RespWidth = WordWidth + IdWidth + 1;

  // Divider iterations, one quotient bit each
  localparam int unsigned DivCycles   = 32;
  localparam int unsigned DivCntWidth = $clog2(DivCycles);

  typedef logic [WordWidth-1:0] word_t;
  typedef logic [IdWidth-1:0]   acc_id_t;

  // Encoded as the RISC-V funct3 of the M extension
  typedef enum logic [OpWidth-1:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } acc_op_e;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

endpackage

// ==== design/unit_if.sv ====
interface unit_if import cc_pkg::*; ();

  // Request towards the unit
  logic    q_valid;
  logic    q_ready;
  acc_op_e q_op;
  acc_id_t q_id;
  word_t   q_arga;
  word_t   q_argb;

  // Response back to the dispatcher
  logic    p_valid;
  logic    p_ready;
  word_t   p_data;
  acc_id_t p_id;

  modport ctrl (
    output q_valid, q_op, q_id, q_arga, q_argb, p_ready,
    input  q_ready, p_valid, p_data, p_id
  );

  modport unit (
    input  q_valid, q_op, q_id, q_arga, q_argb, p_ready,
    output q_ready, p_valid, p_data, p_id
  );

endinterface

// ==== design/spill_reg.sv ====
module spill_reg #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_cut
    logic             main_full_q, spill_full_q;
    logic [Width-1:0] main_data_q, spill_data_q;
    logic             in_fire, main_free;

    // Input stalls only once both slots hold a beat
    assign ready_o   = !spill_full_q;
    assign in_fire   = valid_i && !spill_full_q;
    assign main_free = !main_full_q || ready_i;

    assign valid_o = main_full_q;
    assign data_o  = main_data_q;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        main_full_q  <= 1'b0;
        spill_full_q <= 1'b0;
      end else if (main_free) begin
        // Older spilled beat moves up first
        main_full_q  <= spill_full_q || in_fire;
        spill_full_q <= 1'b0;
      end else if (in_fire) begin
        spill_full_q <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (main_free) begin
        main_data_q <= spill_full_q ? spill_data_q : data_i;
      end else if (in_fire) begin
        spill_data_q <= data_i;
      end
    end
  end

endmodule

// ==== design/mul_unit.sv ====
module mul_unit import cc_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  unit_if.unit acc
);

  logic                          advance;
  logic                          a_signed, b_signed;
  logic                          s1_valid_q, s2_valid_q;
  logic                          s1_hi_q, s2_hi_q;
  acc_id_t                       s1_id_q, s2_id_q;
  logic signed [WordWidth:0]     s1_a_q, s1_b_q;
  logic signed [2*WordWidth+1:0] prod;
  logic [2*WordWidth-1:0]        s2_prod_q;

  // Whole pipe moves together, held while the result waits
  assign advance     = !s2_valid_q || acc.p_ready;
  assign acc.q_ready = advance;

  // MUL gives the same low word under any signedness
  assign a_signed = (acc.q_op == OP_MULH) || (acc.q_op == OP_MULHSU);
  assign b_signed = (acc.q_op == OP_MULH);

  assign prod = s1_a_q * s1_b_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= acc.q_valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      // Stage one, operands widened by one bit
      s1_a_q  <= {a_signed && acc.q_arga[WordWidth-1], acc.q_arga};
      s1_b_q  <= {b_signed && acc.q_argb[WordWidth-1], acc.q_argb};
      s1_hi_q <= (acc.q_op != OP_MUL);
      s1_id_q <= acc.q_id;
      // Stage two, full product
      s2_prod_q <= prod[2*WordWidth-1:0];
      s2_hi_q   <= s1_hi_q;
      s2_id_q   <= s1_id_q;
    end
  end

  assign acc.p_valid = s2_valid_q;
  assign acc.p_id    = s2_id_q;
  assign acc.p_data  = s2_hi_q ? s2_prod_q[2*WordWidth-1:WordWidth] : s2_prod_q[WordWidth-1:0];

endmodule

// ==== design/div_unit.sv ====
module div_unit import cc_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  unit_if.unit acc
);

  div_state_e             state_q;
  logic [DivCntWidth-1:0] cnt_q;
  word_t                  quo_q, rem_q, dvs_q;
  acc_id_t                id_q;
  logic                   rem_sel_q, neg_quo_q, neg_rem_q;
  logic                   accept, is_signed, a_neg, b_neg;
  logic [WordWidth:0]     rem_shift, diff;
  logic                   fits;
  word_t                  quo_out, rem_out;

  assign acc.q_ready = (state_q == DIV_IDLE);
  assign accept      = acc.q_valid && (state_q == DIV_IDLE);

  assign is_signed = (acc.q_op == OP_DIV) || (acc.q_op == OP_REM);
  assign a_neg     = is_signed && acc.q_arga[WordWidth-1];
  assign b_neg     = is_signed && acc.q_argb[WordWidth-1];

  // ---------------------------------------------------------------------------
  // Control
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        DIV_IDLE: begin
          if (acc.q_valid) begin
            state_q <= DIV_RUN;
            cnt_q   <= '0;
          end
        end
        DIV_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == DivCntWidth'(DivCycles - 1)) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (acc.p_ready) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // Restoring datapath on magnitudes
  // ---------------------------------------------------------------------------
  // Dividend shifts out of quo_q while quotient bits shift in
  assign rem_shift = {rem_q, quo_q[WordWidth-1]};
  assign diff      = rem_shift - {1'b0, dvs_q};
  assign fits      = (rem_shift >= {1'b0, dvs_q});

  always_ff @(posedge clk_i) begin
    if (accept) begin
      quo_q     <= a_neg ? -acc.q_arga : acc.q_arga;
      dvs_q     <= b_neg ? -acc.q_argb : acc.q_argb;
      rem_q     <= '0;
      id_q      <= acc.q_id;
      rem_sel_q <= (acc.q_op == OP_REM) || (acc.q_op == OP_REMU);
      // Zero divisor keeps the all-ones quotient unsigned
      neg_quo_q <= (a_neg ^ b_neg) && (acc.q_argb != '0);
      neg_rem_q <= a_neg;
    end else if (state_q == DIV_RUN) begin
      quo_q <= {quo_q[WordWidth-2:0], fits};
      rem_q <= fits ? diff[WordWidth-1:0] : rem_shift[WordWidth-1:0];
    end
  end

  // Signs restored on the way out, overflow falls out naturally
  assign quo_out = neg_quo_q ? -quo_q : quo_q;
  assign rem_out = neg_rem_q ? -rem_q : rem_q;

  assign acc.p_valid = (state_q == DIV_DONE);
  assign acc.p_id    = id_q;
  assign acc.p_data  = rem_sel_q ? rem_out : quo_out;

endmodule

// ==== design/offload_ctrl.sv ====
module offload_ctrl import cc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  // Incoming request
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  logic    in_op_valid_i,
  input  acc_op_e in_op_i,
  input  acc_id_t in_id_i,
  input  word_t   in_arga_i,
  input  word_t   in_argb_i,
  // Merged response
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output word_t   out_data_o,
  output acc_id_t out_id_o,
  output logic    out_error_o,
  // Functional units
  unit_if.ctrl    mul,
  unit_if.ctrl    div
);

  logic       is_div;
  logic       err_valid_q, err_ready, err_push, err_pop;
  acc_id_t    err_id_q;
  logic [2:0] req_vec, gnt, gnt_q;
  logic       hold_q;

  // ---------------------------------------------------------------------------
  // Dispatch
  // ---------------------------------------------------------------------------
  assign is_div = in_op_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

  assign mul.q_valid = in_valid_i && in_op_valid_i && !is_div;
  assign mul.q_op    = in_op_i;
  assign mul.q_id    = in_id_i;
  assign mul.q_arga  = in_arga_i;
  assign mul.q_argb  = in_argb_i;

  assign div.q_valid = in_valid_i && in_op_valid_i && is_div;
  assign div.q_op    = in_op_i;
  assign div.q_id    = in_id_i;
  assign div.q_arga  = in_arga_i;
  assign div.q_argb  = in_argb_i;

  assign err_ready = !err_valid_q || err_pop;
  assign err_push  = in_valid_i && !in_op_valid_i && err_ready;

  always_comb begin
    if (!in_op_valid_i) begin
      in_ready_o = err_ready;
    end else if (is_div) begin
      in_ready_o = div.q_ready;
    end else begin
      in_ready_o = mul.q_ready;
    end
  end

  // Illegal ops answered from a single entry
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else if (err_push) begin
      err_valid_q <= 1'b1;
    end else if (err_pop) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_push) begin
      err_id_q <= in_id_i;
    end
  end

  // ---------------------------------------------------------------------------
  // Response arbitration: divider, then error entry, then multiplier
  // ---------------------------------------------------------------------------
  assign req_vec = {mul.p_valid, err_valid_q, div.p_valid};

  // Grant stays locked while a stalled response waits
  always_comb begin
    gnt = '0;
    if (hold_q) begin
      gnt = gnt_q;
    end else if (req_vec[0]) begin
      gnt[0] = 1'b1;
    end else if (req_vec[1]) begin
      gnt[1] = 1'b1;
    end else if (req_vec[2]) begin
      gnt[2] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_q <= 1'b0;
      gnt_q  <= '0;
    end else begin
      hold_q <= out_valid_o && !out_ready_i;
      gnt_q  <= gnt;
    end
  end

  assign out_valid_o = |gnt;
  assign out_error_o = gnt[1];
  assign div.p_ready = gnt[0] && out_ready_i;
  assign err_pop     = gnt[1] && out_ready_i;
  assign mul.p_ready = gnt[2] && out_ready_i;

  always_comb begin
    out_data_o = '0;
    out_id_o   = '0;
    if (gnt[0]) begin
      out_data_o = div.p_data;
      out_id_o   = div.p_id;
    end else if (gnt[1]) begin
      out_id_o = err_id_q;
    end else if (gnt[2]) begin
      out_data_o = mul.p_data;
      out_id_o   = mul.p_id;
    end
  end

endmodule

// ==== design/cc_offload_top.sv ====
module cc_offload_top import cc_pkg::*; #(
  parameter bit RegisterReq  = 1'b1,
  parameter bit RegisterResp = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_i,
  // Offload request
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  logic    req_op_valid_i,
  input  acc_op_e req_op_i,
  input  acc_id_t req_id_i,
  input  word_t   req_arga_i,
  input  word_t   req_argb_i,
  // Offload response
  output logic    resp_valid_o,
  input  logic    resp_ready_i,
  output word_t   resp_data_o,
  output acc_id_t resp_id_o,
  output logic    resp_error_o
);

  logic [ReqWidth-1:0]  req_d, req_q;
  logic                 req_q_valid, req_q_ready;
  logic [RespWidth-1:0] resp_d, resp_q;
  logic                 resp_d_valid, resp_d_ready;

  // Request fields behind the cut
  logic                 q_op_valid;
  logic [OpWidth-1:0]   q_op_raw;
  acc_id_t              q_id;
  word_t                q_arga, q_argb;

  // Merged response ahead of the cut
  word_t                p_data;
  acc_id_t              p_id;
  logic                 p_error;

  unit_if mul_if ();
  unit_if div_if ();

  assign req_d = {req_op_valid_i, req_op_i, req_id_i, req_arga_i, req_argb_i};
  assign {q_op_valid, q_op_raw, q_id, q_arga, q_argb} = req_q;

  // ---------------------------------------------------------------------------
  // Request cut
  // ---------------------------------------------------------------------------
  spill_reg #(
    .Width  ( ReqWidth     ),
    .Bypass ( !RegisterReq )
  ) i_spill_req (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_d       ),
    .valid_o ( req_q_valid ),
    .ready_i ( req_q_ready ),
    .data_o  ( req_q       )
  );

  offload_ctrl i_offload_ctrl (
    .clk_i         ( clk_i              ),
    .rst_i         ( rst_i              ),
    .in_valid_i    ( req_q_valid        ),
    .in_ready_o    ( req_q_ready        ),
    .in_op_valid_i ( q_op_valid         ),
    .in_op_i       ( acc_op_e'(q_op_raw) ),
    .in_id_i       ( q_id               ),
    .in_arga_i     ( q_arga             ),
    .in_argb_i     ( q_argb             ),
    .out_valid_o   ( resp_d_valid       ),
    .out_ready_i   ( resp_d_ready       ),
    .out_data_o    ( p_data             ),
    .out_id_o      ( p_id               ),
    .out_error_o   ( p_error            ),
    .mul           ( mul_if             ),
    .div           ( div_if             )
  );

  mul_unit i_mul_unit (
    .clk_i ( clk_i  ),
    .rst_i ( rst_i  ),
    .acc   ( mul_if )
  );

  div_unit i_div_unit (
    .clk_i ( clk_i  ),
    .rst_i ( rst_i  ),
    .acc   ( div_if )
  );

  // ---------------------------------------------------------------------------
  // Response cut
  // ---------------------------------------------------------------------------
  assign resp_d = {p_data, p_id, p_error};

  spill_reg #(
    .Width  ( RespWidth     ),
    .Bypass ( !RegisterResp )
  ) i_spill_resp (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( resp_d_valid ),
    .ready_o ( resp_d_ready ),
    .data_i  ( resp_d       ),
    .valid_o ( resp_valid_o ),
    .ready_i ( resp_ready_i ),
    .data_o  ( resp_q       )
  );

  assign {resp_data_o, resp_id_o, resp_error_o} = resp_q;

endmodule

// ==== sim/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int unsigned Period      = 100,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Synchronous reset, released just after the last reset edge
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #10;
    rst_o = 1'b0;
  end

endmodule

// ==== sim/tb_cc_offload_top.sv ====
module tb_cc_offload_top import cc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned DriveDelay = 10;
  localparam int unsigned IdleCycles = 5;
  localparam int unsigned RandPerOp  = 8;
  localparam int unsigned NumIllegal = 4;
  localparam int unsigned OooMuls    = 6;
  localparam int unsigned StreamLen  = 200;
  localparam int unsigned NumReqs    = 2 * (4 * 16 + 4 * RandPerOp) + NumIllegal + OooMuls + 1
                                       + StreamLen;
  localparam word_t Corners [4] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000};

  logic clk_i, rst_i;
  logic req_valid_i, req_ready_o, req_op_valid_i;
  acc_op_e req_op_i;
  acc_id_t req_id_i, resp_id_o;
  word_t req_arga_i, req_argb_i, resp_data_o;
  logic resp_valid_o, resp_ready_i, resp_error_o;

  // Scoreboard by id
  logic [WordWidth:0] exp_resp [32];
  string              exp_test [32];
  logic               pending  [32] = '{default: 1'b0};
  acc_id_t            next_id = '0;

  int errors = 0;
  int checks = 0;
  int accepted = 0;
  int received = 0;
  logic [31:0] stim_lcg = 32'd32787;
  logic [31:0] stall_lcg = 32'd32787;
  logic stall_en = 1'b0;
  logic held = 1'b0;
  logic [RespWidth:0] held_resp, resp_now;

  assign resp_now = {resp_valid_o, resp_data_o, resp_id_o, resp_error_o};

  tb_clk_gen i_clk_gen (
    .clk_o ( clk_i ),
    .rst_o ( rst_i )
  );

  cc_offload_top i_dut (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .req_valid_i    ( req_valid_i    ),
    .req_ready_o    ( req_ready_o    ),
    .req_op_valid_i ( req_op_valid_i ),
    .req_op_i       ( req_op_i       ),
    .req_id_i       ( req_id_i       ),
    .req_arga_i     ( req_arga_i     ),
    .req_argb_i     ( req_argb_i     ),
    .resp_valid_o   ( resp_valid_o   ),
    .resp_ready_i   ( resp_ready_i   ),
    .resp_data_o    ( resp_data_o    ),
    .resp_id_o      ( resp_id_o      ),
    .resp_error_o   ( resp_error_o   )
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Word built from the upper halves of two LCG steps
  function automatic word_t rand_word();
    word_t w;
    stim_lcg = lcg_next(stim_lcg);
    w[31:16] = stim_lcg[31:16];
    stim_lcg = lcg_next(stim_lcg);
    w[15:0] = stim_lcg[31:16];
    return w;
  endfunction

  // Expected {error, result} for one request
  function automatic logic [WordWidth:0] ref_result(input logic op_valid, input acc_op_e op,
                                                    input word_t a, input word_t b);
    longint sa, sb, ua, ub;
    logic [63:0] prod;
    word_t res;
    logic ovf;
    sa = $signed(a);
    sb = $signed(b);
    ua = a;
    ub = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    if (!op_valid) begin
      return {1'b1, 32'd0};
    end
    case (op)
      OP_MUL:    prod = sa * sb;
      OP_MULH:   prod = sa * sb;
      OP_MULHSU: prod = sa * ub;
      default:   prod = ua * ub;
    endcase
    case (op)
      OP_MUL:  res = prod[31:0];
      OP_DIV:  res = (b == 0) ? 32'hFFFF_FFFF : ovf ? a : word_t'(sa / sb);
      OP_DIVU: res = (b == 0) ? 32'hFFFF_FFFF : a / b;
      OP_REM:  res = (b == 0) ? a : ovf ? 32'd0 : word_t'(sa % sb);
      OP_REMU: res = (b == 0) ? a : a % b;
      default: res = prod[63:32];
    endcase
    return {1'b0, res};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic end_run();
    $display("Summary: %0d checks, %0d errors, %0d of %0d responses received",
             checks, errors, received, accepted);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // One request held until the DUT takes it
  task automatic send_req(input string name, input logic op_valid, input acc_op_e op,
                          input word_t a, input word_t b);
    while (pending[next_id]) begin
      next_cycle();
    end
    exp_resp[next_id] = ref_result(op_valid, op, a, b);
    exp_test[next_id] = name;
    pending[next_id]  = 1'b1;
    req_valid_i    = 1'b1;
    req_op_valid_i = op_valid;
    req_op_i       = op;
    req_id_i       = next_id;
    req_arga_i     = a;
    req_argb_i     = b;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    next_cycle();
    req_valid_i = 1'b0;
    accepted++;
    next_id++;
  endtask

  // --------------------------------------------------------------------------
  // Test sequences
  // --------------------------------------------------------------------------
  task automatic run_forms(input int base, input string tag);
    acc_op_e op;
    string name;
    for (int o = 0; o < 4; o++) begin
      op = acc_op_e'(base + o);
      name = $sformatf("%s %s", tag, op.name());
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          send_req(name, 1'b1, op, Corners[i], Corners[j]);
        end
      end
      // Shifted divisors give a spread of quotient sizes
      for (int k = 0; k < RandPerOp; k++) begin
        send_req(name, 1'b1, op, rand_word(), rand_word() >> (4 * k));
      end
    end
  endtask

  task automatic run_stream();
    word_t r;
    stall_en <= 1'b1;
    for (int i = 0; i < StreamLen; i++) begin
      r = rand_word();
      if (r[9:8] == 2'd0) begin
        repeat (r[11:10]) next_cycle();
      end
      send_req("random_stream", r[7:4] != 4'd0, acc_op_e'(r[2:0]), rand_word(), rand_word());
    end
    stall_en <= 1'b0;
  endtask

  initial begin
    req_valid_i    = 1'b0;
    req_op_valid_i = 1'b0;
    req_op_i       = OP_MUL;
    req_id_i       = '0;
    req_arga_i     = '0;
    req_argb_i     = '0;
    wait (rst_i === 1'b0);
    next_cycle();
    repeat (IdleCycles) next_cycle();
    run_forms(0, "mul_forms");
    run_forms(4, "div_forms");
    for (int k = 0; k < NumIllegal; k++) begin
      send_req("illegal_op", 1'b0, acc_op_e'(k), rand_word(), rand_word());
    end
    // Slow divide overtaken by the multiplies behind it
    send_req("out_of_order DIV", 1'b1, OP_DIV, rand_word(), 32'd7);
    for (int k = 0; k < OooMuls; k++) begin
      send_req("out_of_order MULHU", 1'b1, OP_MULHU, rand_word(), rand_word());
    end
    run_stream();
    while (received != accepted) begin
      next_cycle();
    end
    end_run();
  end

  // Response ready toggles randomly only during the stream
  initial begin
    resp_ready_i = 1'b1;
    forever begin
      next_cycle();
      stall_lcg = lcg_next(stall_lcg);
      resp_ready_i = !stall_en || stall_lcg[30];
    end
  end

  // --------------------------------------------------------------------------
  // Monitor sampling at the falling edge
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (accepted == 0) begin
        check_value("idle_after_reset", 64'd0, 64'(resp_valid_o));
      end
      if (held) begin
        check_value("resp_hold_stable", 64'(held_resp), 64'(resp_now));
      end
      held      = resp_valid_o && !resp_ready_i;
      held_resp = resp_now;
      if (resp_valid_o && resp_ready_i) begin
        if (!pending[resp_id_o]) begin
          errors++;
          $display("Response with id %0d arrived but no request is pending for it", resp_id_o);
        end else begin
          check_value(exp_test[resp_id_o], 64'(exp_resp[resp_id_o]),
                      64'({resp_error_o, resp_data_o}));
          pending[resp_id_o] = 1'b0;
          received++;
        end
      end
    end
  end

  initial begin
    repeat (NumReqs * 60 + 200) @(posedge clk_i);
    errors++;
    $display("Timeout: only %0d of %0d responses arrived in time", received, accepted);
    end_run();
  end

endmodule

// ==== vlog.f ====
design/cc_pkg.sv
design/unit_if.sv
design/spill_reg.sv
design/mul_unit.sv
design/div_unit.sv
design/offload_ctrl.sv
design/cc_offload_top.sv
sim/tb_clk_gen.sv
sim/tb_cc_offload_top.sv

// ==== Makefile ====
TOP := tb_cc_offload_top
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
